/* all.f */
+incdir+design
design/clint_axi_pkg.sv
design/clint_reg_pkg.sv
design/clint_axi_front.sv
design/clint_timer_core.sv
design/clint_resp_unit.sv
design/clint_top.sv
sim/clint_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= clint_tb
FILE_LIST ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SRCS := $(shell grep -v '^+' $(FILE_LIST))
HDRS := design/clint_defs.svh
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(HDRS) $(FILE_LIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILE_LIST)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Regression failed" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "Regression passed" $(LOG) || (echo "no pass line in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* sim/clint_tb.sv */
`default_nettype none

`include "clint_defs.svh"

module clint_tb;

    localparam int CLK_HALF   = 4;
    localparam int DRIVE_DLY  = 1;
    localparam int N_TXN      = 400;
    localparam int N_DIRECTED = 3;
    // each access may need two handshakes, forty cycles apiece is generous
    localparam int WD_CYCLES  = (N_TXN * 2 + N_DIRECTED + 8) * 40;

    logic                   clk;
    logic                   rst_n;
    logic                   rtc_tick;
    clint_axi_pkg::axi_aw_t aw;
    logic                   awvalid;
    logic                   awready;
    clint_axi_pkg::axi_w_t  w;
    logic                   wvalid;
    logic                   wready;
    clint_axi_pkg::axi_ar_t ar;
    logic                   arvalid;
    logic                   arready;
    clint_axi_pkg::axi_r_t  r;
    logic                   rvalid;
    logic                   rready;
    clint_axi_pkg::axi_b_t  b;
    logic                   bvalid;
    logic                   bready;
    logic                   timer_irq;
    logic                   soft_irq;

    // reference model state
    logic [63:0] m_mtime;
    logic [63:0] m_mtimecmp;
    logic        m_msip;
    logic        exp_timer;
    logic        exp_soft;

    // expected responses in issue order
    bit          exp_kind_q[$];
    logic [63:0] exp_data_q[$];
    int          sent_cnt;
    int          rsp_cnt;

    logic                  r_held;
    clint_axi_pkg::axi_r_t r_last;
    logic                  b_held;
    clint_axi_pkg::axi_b_t b_last;

    logic [31:0] lcg_state;
    int unsigned kind;
    logic [15:0] rd_off;
    logic [15:0] wr_off;
    logic [63:0] rd_addr;
    logic [63:0] wr_addr;
    logic [63:0] wdata_v;
    logic [7:0]  wstrb_v;
    logic [31:0] hi;
    logic [31:0] lo;

    clint_top clint_top_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .rtc_tick  (rtc_tick),
        .aw        (aw),
        .awvalid   (awvalid),
        .awready   (awready),
        .w         (w),
        .wvalid    (wvalid),
        .wready    (wready),
        .ar        (ar),
        .arvalid   (arvalid),
        .arready   (arready),
        .r         (r),
        .rvalid    (rvalid),
        .rready    (rready),
        .b         (b),
        .bvalid    (bvalid),
        .bready    (bready),
        .timer_irq (timer_irq),
        .soft_irq  (soft_irq)
    );

    always #CLK_HALF clk = ~clk;

    task automatic abort_run();
        $display("Regression failed");
        $fatal(1);
    endtask

    function logic [31:0] rand_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // upper bits only, the low LCG bits repeat quickly
    function int unsigned rand_range(input int unsigned n);
        logic [31:0] v;
        v = rand_next();
        return (v >> 12) % n;
    endfunction

    function logic [15:0] pick_offset();
        logic [31:0] v;
        case (rand_range(4))
            0: return `CLINT_MSIP_OFF;
            1: return `CLINT_MTIMECMP_OFF;
            2: return `CLINT_MTIME_OFF;
            default:
            begin
                v = rand_next();
                return v[31:16];
            end
        endcase
    endfunction

    // bits above the decoded window are noise
    function logic [63:0] make_addr(input logic [15:0] off);
        logic [31:0] a;
        logic [31:0] c;
        a = rand_next();
        c = rand_next();
        return {a, c[31:16], off};
    endfunction

    function automatic logic [63:0] byte_mask(input logic [7:0] strb);
        logic [63:0] m;
        for (int i = 0; i < 8; i++)
        begin
            m[i*8 +: 8] = {8{strb[i]}};
        end
        return m;
    endfunction

    function automatic logic [63:0] model_read(input logic [63:0] addr);
        case (addr[`CLINT_DEC_W-1:0])
            `CLINT_MSIP_OFF:     return {63'h0, m_msip};
            `CLINT_MTIMECMP_OFF: return m_mtimecmp;
            `CLINT_MTIME_OFF:    return m_mtime;
            default:             return 64'h0;
        endcase
    endfunction

    task automatic model_write(input logic [63:0] addr, input logic [63:0] data,
                               input logic [7:0] strb);
        logic [63:0] m;
        m = byte_mask(strb);
        case (addr[`CLINT_DEC_W-1:0])
            `CLINT_MSIP_OFF:
            begin
                if (strb[0])
                begin
                    m_msip = data[0];
                end
            end
            `CLINT_MTIMECMP_OFF: m_mtimecmp = (m_mtimecmp & ~m) | (data & m);
            `CLINT_MTIME_OFF:    m_mtime = (m_mtime & ~m) | (data & m);
            default:
            begin
                // unmapped, write dropped
            end
        endcase
    endtask

    task automatic check_r(input clint_axi_pkg::axi_r_t got,
                           input clint_axi_pkg::axi_r_t exp_val);
        if (got !== exp_val)
        begin
            $display("FAIL t=%0t r: got data=%h resp=%0d, expected data=%h resp=%0d",
                     $time, got.data, got.resp, exp_val.data, exp_val.resp);
            abort_run();
        end
    endtask

    task automatic check_b(input clint_axi_pkg::axi_b_t got,
                           input clint_axi_pkg::axi_b_t exp_val);
        if (got !== exp_val)
        begin
            $display("FAIL t=%0t b.resp: got %0d, expected %0d", $time, got.resp, exp_val.resp);
            abort_run();
        end
    endtask

    task automatic check_irq(input logic got_timer, input logic got_soft,
                             input logic exp_t, input logic exp_s);
        if (got_timer !== exp_t)
        begin
            $display("FAIL t=%0t timer_irq: got %b, expected %b", $time, got_timer, exp_t);
            abort_run();
        end
        if (got_soft !== exp_s)
        begin
            $display("FAIL t=%0t soft_irq: got %b, expected %b", $time, got_soft, exp_s);
            abort_run();
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp_val);
        if (got !== exp_val)
        begin
            $display("FAIL t=%0t %s: got %b, expected %b", $time, name, got, exp_val);
            abort_run();
        end
    endtask

    task automatic take_response(input bit is_read);
        bit                    kind_e;
        logic [63:0]           data_e;
        clint_axi_pkg::axi_r_t r_exp;
        clint_axi_pkg::axi_b_t b_exp;
        if (exp_kind_q.size() == 0)
        begin
            $display("error: response at %0t with no request outstanding", $time);
            abort_run();
        end
        kind_e = exp_kind_q.pop_front();
        data_e = exp_data_q.pop_front();
        if (kind_e != is_read)
        begin
            $display("error: response at %0t is not the kind of the oldest request", $time);
            abort_run();
        end
        if (is_read)
        begin
            r_exp.data = data_e;
            r_exp.resp = clint_axi_pkg::OKAY;
            check_r(r, r_exp);
        end
        else
        begin
            b_exp.resp = clint_axi_pkg::OKAY;
            check_b(b, b_exp);
        end
        rsp_cnt++;
    endtask

    // everything the DUT sees is stable here, the next rising edge acts on it
    always @(negedge clk)
    begin
        if (rst_n)
        begin
            check_irq(timer_irq, soft_irq, exp_timer, exp_soft);
            exp_timer = (m_mtime >= m_mtimecmp);
            exp_soft  = m_msip;
            if (r_held && (!rvalid || r !== r_last))
            begin
                $display("error: R response at %0t dropped or changed before rready", $time);
                abort_run();
            end
            if (b_held && (!bvalid || b !== b_last))
            begin
                $display("error: B response at %0t dropped or changed before bready", $time);
                abort_run();
            end
            if (rvalid && rready)
            begin
                take_response(1'b1);
            end
            if (bvalid && bready)
            begin
                take_response(1'b0);
            end
            r_held = rvalid && !rready;
            r_last = r;
            b_held = bvalid && !bready;
            b_last = b;
            // read value is taken before this edge's tick or write
            if (arvalid && arready)
            begin
                exp_kind_q.push_back(1'b1);
                exp_data_q.push_back(model_read(ar.addr));
            end
            if (awvalid && awready && wvalid && wready)
            begin
                exp_kind_q.push_back(1'b0);
                exp_data_q.push_back(64'h0);
                model_write(aw.addr, w.data, w.strb);
            end
            if (rtc_tick && !(awvalid && awready &&
                              aw.addr[`CLINT_DEC_W-1:0] == `CLINT_MTIME_OFF))
            begin
                m_mtime = m_mtime + 64'd1;
            end
        end
    end

    task automatic next_cycle();
        @(posedge clk);
        #DRIVE_DLY;
        rtc_tick = (rand_range(2) == 0);
        rready   = (rand_range(4) != 0);
        bready   = (rand_range(4) != 0);
    endtask

    // holds each valid until its handshake edge has passed
    task automatic run_access(input bit do_rd, input bit do_wr,
                              input logic [63:0] ar_addr, input logic [63:0] aw_addr,
                              input logic [63:0] data, input logic [7:0] strb);
        bit          rd_left;
        bit          wr_left;
        logic [31:0] p;
        next_cycle();
        p       = rand_next();
        rd_left = do_rd;
        wr_left = do_wr;
        ar.addr = ar_addr;
        ar.prot = p[31:29];
        aw.addr = aw_addr;
        aw.prot = p[28:26];
        w.data  = data;
        w.strb  = strb;
        arvalid = do_rd;
        awvalid = do_wr;
        wvalid  = do_wr;
        sent_cnt = sent_cnt + int'(do_rd) + int'(do_wr);
        while (rd_left || wr_left)
        begin
            @(negedge clk);
            if (arvalid && arready)
            begin
                rd_left = 1'b0;
            end
            if (awvalid && awready)
            begin
                wr_left = 1'b0;
            end
            next_cycle();
            arvalid = rd_left;
            awvalid = wr_left;
            wvalid  = wr_left;
        end
    endtask

    initial
    begin
        repeat (WD_CYCLES) @(posedge clk);
        $display("error: watchdog expired after %0d cycles", WD_CYCLES);
        abort_run();
    end

    initial
    begin
        clk        = 1'b0;
        rst_n      = 1'b0;
        rtc_tick   = 1'b0;
        aw         = '0;
        awvalid    = 1'b0;
        w          = '0;
        wvalid     = 1'b0;
        ar         = '0;
        arvalid    = 1'b0;
        rready     = 1'b0;
        bready     = 1'b0;
        lcg_state  = 32'h5de0_1a43;
        m_mtime    = 64'h0;
        m_mtimecmp = 64'hffff_ffff_ffff_ffff;
        m_msip     = 1'b0;
        exp_timer  = 1'b0;
        exp_soft   = 1'b0;
        r_held     = 1'b0;
        b_held     = 1'b0;
        sent_cnt   = 0;
        rsp_cnt    = 0;
        repeat (4) @(posedge clk);
        #DRIVE_DLY;
        rst_n = 1'b1;
        @(negedge clk);
        check_bit("arready", arready, 1'b0);
        check_bit("awready", awready, 1'b0);
        check_bit("wready", wready, 1'b0);
        check_bit("rvalid", rvalid, 1'b0);
        check_bit("bvalid", bvalid, 1'b0);
        check_bit("timer_irq", timer_irq, 1'b0);
        check_bit("soft_irq", soft_irq, 1'b0);
        // reset values read back first
        rd_addr = make_addr(`CLINT_MTIMECMP_OFF);
        run_access(1'b1, 1'b0, rd_addr, 64'h0, 64'h0, 8'h0);
        rd_addr = make_addr(`CLINT_MSIP_OFF);
        run_access(1'b1, 1'b0, rd_addr, 64'h0, 64'h0, 8'h0);
        rd_addr = make_addr(`CLINT_MTIME_OFF);
        run_access(1'b1, 1'b0, rd_addr, 64'h0, 64'h0, 8'h0);
        for (int n = 0; n < N_TXN; n++)
        begin
            kind    = rand_range(10);
            rd_off  = pick_offset();
            rd_addr = make_addr(rd_off);
            wr_off  = pick_offset();
            wr_addr = make_addr(wr_off);
            hi      = rand_next();
            lo      = rand_next();
            // small values make the compare against mtime interesting
            wdata_v = (rand_range(2) == 0) ? {56'h0, lo[7:0]} : {hi, lo};
            lo      = rand_next();
            wstrb_v = (rand_range(2) == 0) ? 8'hff : lo[31:24];
            run_access(kind < 5 || kind == 9, kind >= 5, rd_addr, wr_addr, wdata_v, wstrb_v);
            repeat (rand_range(3)) next_cycle();
        end
        while (exp_kind_q.size() != 0)
        begin
            next_cycle();
        end
        repeat (3) next_cycle();
        if (sent_cnt == rsp_cnt && !rvalid && !bvalid)
        begin
            $display("Regression passed");
            $finish;
        end
        else
        begin
            $display("error: %0d requests sent but %0d responses taken", sent_cnt, rsp_cnt);
            abort_run();
        end
    end

endmodule

`default_nettype wire

/* design/clint_top.sv */
`default_nettype none

module clint_top (
    input  wire                            clk,
    input  wire                            rst_n,
    input  wire                            rtc_tick,
    input  wire clint_axi_pkg::axi_aw_t    aw,
    input  wire                            awvalid,
    output logic                           awready,
    input  wire clint_axi_pkg::axi_w_t     w,
    input  wire                            wvalid,
    output logic                           wready,
    input  wire clint_axi_pkg::axi_ar_t    ar,
    input  wire                            arvalid,
    output logic                           arready,
    output clint_axi_pkg::axi_r_t          r,
    output logic                           rvalid,
    input  wire                            rready,
    output clint_axi_pkg::axi_b_t          b,
    output logic                           bvalid,
    input  wire                            bready,
    output logic                           timer_irq,
    output logic                           soft_irq
);

    clint_reg_pkg::reg_req_t reg_req;
    clint_reg_pkg::reg_rsp_t reg_rsp;
    logic                    resp_busy;

    clint_axi_front clint_axi_front_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .aw        (aw),
        .awvalid   (awvalid),
        .w         (w),
        .wvalid    (wvalid),
        .ar        (ar),
        .arvalid   (arvalid),
        .resp_busy (resp_busy),
        .awready   (awready),
        .wready    (wready),
        .arready   (arready),
        .reg_req   (reg_req)
    );

    clint_timer_core clint_timer_core_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .rtc_tick  (rtc_tick),
        .reg_req   (reg_req),
        .reg_rsp   (reg_rsp),
        .timer_irq (timer_irq),
        .soft_irq  (soft_irq)
    );

    clint_resp_unit clint_resp_unit_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .reg_rsp   (reg_rsp),
        .rready    (rready),
        .bready    (bready),
        .r         (r),
        .rvalid    (rvalid),
        .b         (b),
        .bvalid    (bvalid),
        .resp_busy (resp_busy)
    );

endmodule

`default_nettype wire

/* design/clint_resp_unit.sv */
`default_nettype none

module clint_resp_unit (
    input  wire                            clk,
    input  wire                            rst_n,
    input  wire clint_reg_pkg::reg_rsp_t   reg_rsp,
    input  wire                            rready,
    input  wire                            bready,
    output clint_axi_pkg::axi_r_t          r,
    output logic                           rvalid,
    output clint_axi_pkg::axi_b_t          b,
    output logic                           bvalid,
    output logic                           resp_busy
);

    logic [63:0] rdata_q;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            rvalid <= 1'b0;
            bvalid <= 1'b0;
        end
        else
        begin
            if (reg_rsp.valid && reg_rsp.is_read)
            begin
                rvalid <= 1'b1;
            end
            else if (rready)
            begin
                rvalid <= 1'b0;
            end
            if (reg_rsp.valid && !reg_rsp.is_read)
            begin
                bvalid <= 1'b1;
            end
            else if (bready)
            begin
                bvalid <= 1'b0;
            end
        end
    end

    // read data capture
    always_ff @(posedge clk)
    begin
        if (reg_rsp.valid && reg_rsp.is_read)
        begin
            rdata_q <= reg_rsp.rdata;
        end
    end

    assign r.data    = rdata_q;
    assign r.resp    = clint_axi_pkg::OKAY;
    assign b.resp    = clint_axi_pkg::OKAY;
    // front must hold off while anything waits here
    assign resp_busy = rvalid || bvalid;

    // relies on the front never issuing while busy
    a_one_resp: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(rvalid && bvalid)
    );

endmodule

`default_nettype wire

/* design/clint_timer_core.sv */
`default_nettype none

`include "clint_defs.svh"

module clint_timer_core (
    input  wire                            clk,
    input  wire                            rst_n,
    input  wire                            rtc_tick,
    input  wire clint_reg_pkg::reg_req_t   reg_req,
    output clint_reg_pkg::reg_rsp_t        reg_rsp,
    output logic                           timer_irq,
    output logic                           soft_irq
);

    logic [63:0] mtime_q;
    logic [63:0] mtimecmp_q;
    logic [63:0] msip_q;
    logic        wr_msip;
    logic        wr_mtimecmp;
    logic        wr_mtime;

    // keep old bytes where the strobe is low
    function automatic logic [63:0] merge_bytes(
        input logic [63:0] old_val,
        input logic [63:0] new_val,
        input logic [7:0]  strb
    );
        logic [63:0] res;
        res = old_val;
        for (int i = 0; i < 8; i++)
        begin
            if (strb[i])
            begin
                res[i*8 +: 8] = new_val[i*8 +: 8];
            end
        end
        return res;
    endfunction

    assign wr_msip     = reg_req.valid && (reg_req.op == clint_reg_pkg::OP_WR_MSIP);
    assign wr_mtimecmp = reg_req.valid && (reg_req.op == clint_reg_pkg::OP_WR_MTIMECMP);
    assign wr_mtime    = reg_req.valid && (reg_req.op == clint_reg_pkg::OP_WR_MTIME);

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            mtime_q    <= 64'h0;
            mtimecmp_q <= `CLINT_MTIMECMP_RST;
            msip_q     <= 64'h0;
        end
        else
        begin
            // a bus write beats the tick
            if (wr_mtime)
            begin
                mtime_q <= merge_bytes(mtime_q, reg_req.wdata, reg_req.wstrb);
            end
            else if (rtc_tick)
            begin
                mtime_q <= mtime_q + 64'd1;
            end
            if (wr_mtimecmp)
            begin
                mtimecmp_q <= merge_bytes(mtimecmp_q, reg_req.wdata, reg_req.wstrb);
            end
            // msip implements bit 0 only
            if (wr_msip)
            begin
                msip_q <= merge_bytes(msip_q, reg_req.wdata & 64'h1, reg_req.wstrb);
            end
        end
    end

    // read value taken before this edge's update
    always_comb
    begin
        reg_rsp.valid   = reg_req.valid;
        reg_rsp.is_read = reg_req.op inside {clint_reg_pkg::OP_RD_MSIP,
                                             clint_reg_pkg::OP_RD_MTIMECMP,
                                             clint_reg_pkg::OP_RD_MTIME,
                                             clint_reg_pkg::OP_RD_NONE};
        case (reg_req.op)
            clint_reg_pkg::OP_RD_MSIP:     reg_rsp.rdata = msip_q;
            clint_reg_pkg::OP_RD_MTIMECMP: reg_rsp.rdata = mtimecmp_q;
            clint_reg_pkg::OP_RD_MTIME:    reg_rsp.rdata = mtime_q;
            default:                       reg_rsp.rdata = 64'h0;
        endcase
    end

    // interrupt levels lag the registers by one cycle
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            timer_irq <= 1'b0;
            soft_irq  <= 1'b0;
        end
        else
        begin
            timer_irq <= (mtime_q >= mtimecmp_q);
            soft_irq  <= msip_q[0];
        end
    end

    a_msip_bit0_only: assert property (
        @(posedge clk) disable iff (!rst_n)
        msip_q[63:1] == 63'h0
    );

endmodule

`default_nettype wire

/* design/clint_axi_front.sv */
`default_nettype none

`include "clint_defs.svh"

module clint_axi_front (
    input  wire                            clk,
    input  wire                            rst_n,
    input  wire clint_axi_pkg::axi_aw_t    aw,
    input  wire                            awvalid,
    input  wire clint_axi_pkg::axi_w_t     w,
    input  wire                            wvalid,
    input  wire clint_axi_pkg::axi_ar_t    ar,
    input  wire                            arvalid,
    input  wire                            resp_busy,
    output logic                           awready,
    output logic                           wready,
    output logic                           arready,
    output clint_reg_pkg::reg_req_t        reg_req
);

    typedef enum logic {
        IDLE,
        ACCEPT
    } state_e;

    state_e                   state_q;
    logic                     rd_sel_q;
    logic [`CLINT_DEC_W-1:0]  dec_addr;
    clint_reg_pkg::reg_op_e   dec_op;

    // arbitration, reads win over a write arriving in the same cycle
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state_q  <= IDLE;
            rd_sel_q <= 1'b0;
        end
        else
        begin
            case (state_q)
                IDLE:
                begin
                    if (!resp_busy && arvalid)
                    begin
                        state_q  <= ACCEPT;
                        rd_sel_q <= 1'b1;
                    end
                    else if (!resp_busy && awvalid && wvalid)
                    begin
                        state_q  <= ACCEPT;
                        rd_sel_q <= 1'b0;
                    end
                end
                default:
                begin
                    // accept lasts one cycle only
                    state_q <= IDLE;
                end
            endcase
        end
    end

    // ready pulses come straight from the registered state
    assign arready = (state_q == ACCEPT) && rd_sel_q;
    assign awready = (state_q == ACCEPT) && !rd_sel_q;
    assign wready  = (state_q == ACCEPT) && !rd_sel_q;

    // address decode of the winning channel
    always_comb
    begin
        dec_addr = rd_sel_q ? ar.addr[`CLINT_DEC_W-1:0] : aw.addr[`CLINT_DEC_W-1:0];
        case (dec_addr)
            `CLINT_MSIP_OFF:
                dec_op = rd_sel_q ? clint_reg_pkg::OP_RD_MSIP : clint_reg_pkg::OP_WR_MSIP;
            `CLINT_MTIMECMP_OFF:
                dec_op = rd_sel_q ? clint_reg_pkg::OP_RD_MTIMECMP
                                  : clint_reg_pkg::OP_WR_MTIMECMP;
            `CLINT_MTIME_OFF:
                dec_op = rd_sel_q ? clint_reg_pkg::OP_RD_MTIME : clint_reg_pkg::OP_WR_MTIME;
            default:
                dec_op = rd_sel_q ? clint_reg_pkg::OP_RD_NONE : clint_reg_pkg::OP_WR_NONE;
        endcase
    end

    // request fires in the transfer cycle itself
    always_comb
    begin
        reg_req.valid = (state_q == ACCEPT);
        reg_req.op    = dec_op;
        reg_req.wdata = rd_sel_q ? 64'h0 : w.data;
        reg_req.wstrb = rd_sel_q ? 8'h0 : w.strb;
    end

    // AW and W complete together, and only against a master still holding both valids
    a_aw_w_paired: assert property (
        @(posedge clk) disable iff (!rst_n)
        (awready || wready) |-> (awready && wready && awvalid && wvalid)
    );

endmodule

`default_nettype wire

/* design/clint_reg_pkg.sv */
`default_nettype none

package clint_reg_pkg;

    // one opcode per register and direction
    // the _NONE codes cover unmapped offsets
    typedef enum logic [2:0] {
        OP_RD_MSIP,
        OP_RD_MTIMECMP,
        OP_RD_MTIME,
        OP_RD_NONE,
        OP_WR_MSIP,
        OP_WR_MTIMECMP,
        OP_WR_MTIME,
        OP_WR_NONE
    } reg_op_e;

    // single cycle strobe from the front into the core
    typedef struct packed {
        logic        valid;
        reg_op_e     op;
        logic [63:0] wdata;
        logic [7:0]  wstrb;
    } reg_req_t;

    // returned by the core in the same cycle as the request
    typedef struct packed {
        logic        valid;
        logic        is_read;
        logic [63:0] rdata;
    } reg_rsp_t;

endpackage

`default_nettype wire

/* design/clint_axi_pkg.sv */
`default_nettype none

package clint_axi_pkg;

    // standard AXI response codes
    // this slave only ever returns OKAY
    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        EXOKAY = 2'b01,
        SLVERR = 2'b10,
        DECERR = 2'b11
    } axi_resp_e;

    typedef struct packed {
        logic [63:0] addr;
        logic [2:0]  prot;
    } axi_aw_t;

    typedef struct packed {
        logic [63:0] data;
        logic [7:0]  strb;
    } axi_w_t;

    typedef struct packed {
        logic [63:0] addr;
        logic [2:0]  prot;
    } axi_ar_t;

    typedef struct packed {
        logic [63:0] data;
        axi_resp_e   resp;
    } axi_r_t;

    typedef struct packed {
        axi_resp_e resp;
    } axi_b_t;

endpackage

`default_nettype wire

/* design/clint_defs.svh */
`ifndef CLINT_DEFS_SVH
`define CLINT_DEFS_SVH

// only the low address bits take part in decoding
`define CLINT_DEC_W 16

// register offsets inside the decoded window
`define CLINT_MSIP_OFF 16'h0000
`define CLINT_MTIMECMP_OFF 16'h4000
`define CLINT_MTIME_OFF 16'hbff8

// compare value out of reset
// all ones keeps the timer interrupt quiet until software programs it
`define CLINT_MTIMECMP_RST 64'hffff_ffff_ffff_ffff

`endif
